/* source/magPkg.sv */
// Datapath sizes for the vector magnitude unit
// Operand, sum-of-squares and root widths
// Number of shift-subtract steps per root

`default_nettype none

package magPkg;

	// ====================
	// Operand side
	// ====================

	// Each signed input coordinate
	localparam int OperandWidth = 16;

	// Exact x^2 + y^2, largest value is 2^31
	localparam int SumWidth = 32;

	// ====================
	// Root side
	// ====================

	// Floor square root of the sum
	localparam int RootWidth = 16;

	// Two sum bits are consumed per step
	localparam int IterCount = 16;

endpackage

`default_nettype wire

/* source/ctrlPkg.sv */
// Controller definitions for the vector magnitude unit
// State encoding of the sequencer
// Width of the iteration counter

`default_nettype none

package ctrlPkg;

	// Sequencer states, 3-bit encoding
	typedef enum logic [2:0] {
		Idle,
		Capture,
		Seed,
		Iterate,
		Done
	} CtrlState;

	// Must hold the terminal count of 16
	localparam int CountWidth = 5;

endpackage

`default_nettype wire

/* source/magCtrl.sv */
// Sequencer for the vector magnitude unit
// Idle -> Seed -> Iterate -> Done -> Idle
// Decodes the capture, seed and step strobes
// All strobes are qualified by the clock enable

`timescale 1ns/1ps
`default_nettype none

module magCtrl import ctrlPkg::*; (
	input  wire  clk,
	input  wire  rst,
	input  wire  ce,
	input  wire  ld,
	input  wire  cntDone,
	output logic capture,
	output logic seed,
	output logic step,
	output logic done
);

	CtrlState state;

	// ====================
	// Strobe decode
	// ====================

	// Load only accepted while idle
	assign capture = ce && (state == Idle) && ld;

	// One seed edge right after the capture edge
	assign seed = ce && (state == Seed);

	// Steps run until the counter reaches its terminal value
	assign step = ce && (state == Iterate) && !cntDone;

	// Done level is the plain state decode
	// it stays up through a ce stall
	assign done = (state == Done);

	// ====================
	// State register
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= Idle;
		end else if (ce) begin
			case (state)
				Idle: begin
					// Operands are registered on this same edge
					if (ld) begin
						state <= Seed;
					end
				end
				Seed: begin
					state <= Iterate;
				end
				Iterate: begin
					// Leave once all steps have been taken
					if (cntDone) begin
						state <= Done;
					end
				end
				Done: begin
					state <= Idle;
				end
				default: begin
					state <= Idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/iterCounter.sv */
// Iteration counter for the square root loop
// Clears to zero, counts up to IterCount and holds there
// Terminal flag tells the sequencer the root is complete

`timescale 1ns/1ps
`default_nettype none

module iterCounter import magPkg::*, ctrlPkg::*; (
	input  wire  clk,
	input  wire  rst,
	input  wire  clear,
	input  wire  advance,
	output logic cntDone
);

	localparam logic [CountWidth-1:0] TermCount = CountWidth'(IterCount);

	logic [CountWidth-1:0] count;

	// Reset parks the counter at its terminal value
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= TermCount;
		end else if (clear) begin
			count <= '0;
		end else if (advance && (count < TermCount)) begin
			// Saturates at the terminal value
			count <= count + 1'b1;
		end
	end

	assign cntDone = (count == TermCount);

endmodule

`default_nettype wire

/* source/sumSquares.sv */
// Sum of squares stage
// Absolute values of both signed operands
// Two unsigned squares and their registered sum

`timescale 1ns/1ps
`default_nettype none

module sumSquares import magPkg::*; (
	input  wire                            clk,
	input  wire                            rst,
	input  wire                            capture,
	input  wire signed [OperandWidth-1:0] x,
	input  wire signed [OperandWidth-1:0] y,
	output logic       [SumWidth-1:0]     sumSq
);

	logic [OperandWidth-1:0] xAbs;
	logic [OperandWidth-1:0] yAbs;
	logic [SumWidth-1:0]     xSq;
	logic [SumWidth-1:0]     ySq;

	// Magnitudes as unsigned words
	// -32768 negates to 0x8000 which reads as 32768 unsigned
	assign xAbs = x[OperandWidth-1] ? OperandWidth'(-x) : OperandWidth'(x);
	assign yAbs = y[OperandWidth-1] ? OperandWidth'(-y) : OperandWidth'(y);

	// Full-width products of at most 2^30 each
	assign xSq = SumWidth'(xAbs) * SumWidth'(xAbs);
	assign ySq = SumWidth'(yAbs) * SumWidth'(yAbs);

	// Sum peaks at 2^31 so the word never carries out
	always_ff @(posedge clk) begin
		if (rst) begin
			sumSq <= '0;
		end else if (capture) begin
			sumSq <= xSq + ySq;
		end
	end

endmodule

`default_nettype wire

/* source/rootStep.sv */
// Restoring square root datapath
// Low remainder feeds two bits per step into the high remainder
// Partial root grows by one bit per step
// Root register drives the magnitude output

`timescale 1ns/1ps
`default_nettype none

module rootStep import magPkg::*; (
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  seed,
	input  wire                  step,
	input  wire  [SumWidth-1:0]  sumSq,
	output logic [RootWidth-1:0] mag
);

	// ====================
	// Working registers
	// ====================

	// Unconsumed sum bits, top pair used first
	logic [SumWidth-1:0] remLo;

	// Running remainder, never above twice the partial root
	logic [RootWidth+1:0] remHi;

	// Partial root
	logic [RootWidth-1:0] root;

	// ====================
	// Step arithmetic
	// ====================

	logic [RootWidth+3:0] remHiShift;
	logic [RootWidth+3:0] trialDiv;
	logic [RootWidth+3:0] remDiff;
	logic                 fits;

	// Bring down the next two bits of the sum
	assign remHiShift = {remHi, remLo[SumWidth-1 -: 2]};

	// Partial root doubled, then shifted with a trailing one
	// i.e. 4*root + 1
	assign trialDiv = {2'b00, root, 2'b01};

	assign fits    = (remHiShift >= trialDiv);
	assign remDiff = remHiShift - trialDiv;

	always_ff @(posedge clk) begin
		if (rst) begin
			remLo <= '0;
			remHi <= '0;
			root  <= '0;
		end else if (seed) begin
			// Start a new root from the captured sum
			remLo <= sumSq;
			remHi <= '0;
			root  <= '0;
		end else if (step) begin
			remLo <= {remLo[SumWidth-3:0], 2'b00};
			// Restore when the trial divisor does not fit
			remHi <= fits ? remDiff[RootWidth+1:0] : remHiShift[RootWidth+1:0];
			// New root bit is the compare result
			root  <= {root[RootWidth-2:0], fits};
		end
	end

	assign mag = root;

endmodule

`default_nettype wire

/* source/magnitudeUnit.sv */
// Vector magnitude unit, top level
// floor(sqrt(x^2 + y^2)) for signed 16-bit x and y
// Sequencer, iteration counter, sum-of-squares stage and root datapath
// ce low freezes the whole unit

`timescale 1ns/1ps
`default_nettype none

module magnitudeUnit import magPkg::*; (
	input  wire                            clk,
	input  wire                            rst,
	input  wire                            ce,
	input  wire                            ld,
	input  wire signed [OperandWidth-1:0] x,
	input  wire signed [OperandWidth-1:0] y,
	output logic       [RootWidth-1:0]    mag,
	output logic                           done
);

	// Strobes from the sequencer, already qualified by ce
	logic capture;
	logic seed;
	logic step;

	// Counter terminal flag
	logic cntDone;

	// Registered sum of squares
	logic [SumWidth-1:0] sumSq;

	// ====================
	// Control
	// ====================

	magCtrl ctrl (
		.clk     (clk),
		.rst     (rst),
		.ce      (ce),
		.ld      (ld),
		.cntDone (cntDone),
		.capture (capture),
		.seed    (seed),
		.step    (step),
		.done    (done)
	);

	// Seed clears the count, each step advances it
	iterCounter counter (
		.clk     (clk),
		.rst     (rst),
		.clear   (seed),
		.advance (step),
		.cntDone (cntDone)
	);

	// ====================
	// Datapath
	// ====================

	sumSquares squares (
		.clk     (clk),
		.rst     (rst),
		.capture (capture),
		.x       (x),
		.y       (y),
		.sumSq   (sumSq)
	);

	rootStep root (
		.clk   (clk),
		.rst   (rst),
		.seed  (seed),
		.step  (step),
		.sumSq (sumSq),
		.mag   (mag)
	);

endmodule

`default_nettype wire

/* tb/magTb.sv */
// Testbench for the vector magnitude unit
// Clock, reset, LCG and a bit-by-bit reference square root
// Directed tests for reset state, fixed pairs, random pairs,
// clock-enable stalls and loads issued while busy
// Cycle counter that stops a run that hangs

`timescale 1ns/1ps
`default_nettype none

module magTb import magPkg::*; ();

	localparam int ClkHalf = 2;
	// Enabled edges from the load edge to done
	localparam int Latency = 18;
	// About 40 operations at 20 cycles, doubled for stalls
	localparam int TimeoutCycles = 2000;

	logic clk;
	logic rst;
	logic ce;
	logic ld;
	logic signed [OperandWidth-1:0] x;
	logic signed [OperandWidth-1:0] y;
	logic [RootWidth-1:0] mag;
	logic done;

	int unsigned lcgState;
	int cycleCount = 0;

	magnitudeUnit UUT (
		.clk  (clk),
		.rst  (rst),
		.ce   (ce),
		.ld   (ld),
		.x    (x),
		.y    (y),
		.mag  (mag),
		.done (done)
	);

	// ====================
	// Clock and timeout
	// ====================

	initial begin
		clk = 1'b0;
		forever #ClkHalf clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			stopRun("Timeout, the tests did not finish within the cycle limit");
		end
	end

	// ====================
	// Helpers
	// ====================

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "run stopped");
	endtask

	// Upper half of the LCG state, low bits are too regular
	function automatic logic [15:0] lcgNext();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[31:16];
	endfunction

	// Largest r with r*r <= a*a + b*b, one root bit at a time from the top
	function automatic logic [RootWidth-1:0] refMag(input logic signed [15:0] a,
			input logic signed [15:0] b);
		longint sum;
		longint cand;
		logic [RootWidth-1:0] r;
		sum = longint'(a) * longint'(a) + longint'(b) * longint'(b);
		r = '0;
		for (int i = RootWidth - 1; i >= 0; i--) begin
			cand = longint'(r) | (longint'(1) << i);
			if (cand * cand <= sum) begin
				r = cand[RootWidth-1:0];
			end
		end
		return r;
	endfunction

	task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			stopRun($sformatf("ERR %s got %h expected %h", name, got, exp));
		end
	endtask

	// One operation from load to idle
	// e counts enabled edges after the load edge, state before edge e+1 is
	// Seed for e=0, Iterate for 1..17, Done for 18
	task automatic runOp(input logic [15:0] a, input logic [15:0] b,
			input logic [RootWidth-1:0] expMag, input int stallPct,
			input int doneHold, input bit strayLoads);
		int edges;
		int stalls;
		bit nextCe;
		edges = 0;
		stalls = 0;
		@(posedge clk);
		ce <= 1'b1;
		ld <= 1'b1;
		x <= a;
		y <= b;
		@(posedge clk);
		// Load edge just passed
		ld <= 1'b0;
		forever begin
			nextCe = 1'b1;
			// Random stalls in Seed and Iterate
			if (edges - stalls < Latency && lcgNext() % 100 < stallPct) begin
				nextCe = 1'b0;
			end
			// First held cycle in Done
			if (edges - stalls == Latency && doneHold > 0) begin
				nextCe = 1'b0;
			end
			ce <= nextCe;
			// Stray loads while busy, always one in Done
			if (strayLoads && edges - stalls <= Latency) begin
				ld <= lcgNext() % 2 == 1 || edges - stalls == Latency;
				x <= lcgNext();
				y <= lcgNext();
			end
			@(negedge clk);
			if (done) begin
				assert (edges - stalls == Latency) else begin
					stopRun($sformatf("done rose after %0d enabled edges", edges - stalls));
				end
				break;
			end
			assert (edges - stalls < Latency) else begin
				stopRun("done did not rise after the expected number of edges");
			end
			@(posedge clk);
			edges++;
			if (!nextCe) begin
				stalls++;
			end
		end
		checkVal("mag", 32'(mag), 32'(expMag));
		// Done level holds through a stall
		for (int k = 0; k < doneHold; k++) begin
			@(posedge clk);
			if (k == doneHold - 1) begin
				ce <= 1'b1;
			end
			@(negedge clk);
			checkVal("done", 32'(done), 32'd1);
		end
		// Exit edge back to Idle
		@(posedge clk);
		ce <= 1'b1;
		ld <= 1'b0;
		@(negedge clk);
		checkVal("done", 32'(done), 32'd0);
		checkVal("mag", 32'(mag), 32'(expMag));
		// No load, so the result must stay put
		repeat (2) begin
			@(negedge clk);
			checkVal("done", 32'(done), 32'd0);
			checkVal("mag", 32'(mag), 32'(expMag));
		end
	endtask

	// ====================
	// Tests
	// ====================

	task automatic resetTest();
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		checkVal("mag", 32'(mag), 32'd0);
		// Idle with ld low never reports done
		repeat (10) begin
			@(negedge clk);
			checkVal("done", 32'(done), 32'd0);
		end
	endtask

	task automatic directedTest();
		runOp(16'sd3, 16'sd4, 16'd5, 0, 0, 1'b0);
		runOp(-16'sd5, 16'sd12, 16'd13, 0, 0, 1'b0);
		runOp(16'sd0, 16'sd0, 16'd0, 0, 0, 1'b0);
		runOp(16'sd1, 16'sd1, 16'd1, 0, 0, 1'b0);
		// Most negative operands, sum is 2^31
		runOp(16'sh8000, 16'sh8000, 16'd46340, 0, 0, 1'b0);
	endtask

	task automatic randomTest();
		logic [15:0] a;
		logic [15:0] b;
		repeat (20) begin
			a = lcgNext();
			b = lcgNext();
			runOp(a, b, refMag(a, b), 0, 0, 1'b0);
		end
	endtask

	task automatic stallTest();
		logic [15:0] a;
		logic [15:0] b;
		for (int i = 0; i < 6; i++) begin
			a = lcgNext();
			b = lcgNext();
			runOp(a, b, refMag(a, b), 30, 1 + i % 3, 1'b0);
		end
	endtask

	task automatic strayLoadTest();
		logic [15:0] a;
		logic [15:0] b;
		for (int i = 0; i < 4; i++) begin
			a = lcgNext();
			b = lcgNext();
			runOp(a, b, refMag(a, b), 20, i % 2 * 2, 1'b1);
		end
	endtask

	initial begin
		lcgState = 32'd19208;
		rst <= 1'b1;
		ce <= 1'b1;
		ld <= 1'b0;
		x <= '0;
		y <= '0;
		resetTest();
		directedTest();
		randomTest();
		stallTest();
		strayLoadTest();
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
source/magPkg.sv
source/ctrlPkg.sv
source/magCtrl.sv
source/iterCounter.sv
source/sumSquares.sv
source/rootStep.sv
source/magnitudeUnit.sv
tb/magTb.sv

/* Makefile */
# Verilator build and run for the vector magnitude unit

VERILATOR ?= verilator
TOP       ?= magTb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q -F -e '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
